// File: verilog/wbuf_pkg.sv
// Geometry fixed at 32-bit words, 8 ways of 64 sets and a 22-bit physical address
package wbuf_pkg;

  // ============================================================
  // Cache geometry
  // ============================================================
  localparam int data_width_lp   = 32;
  localparam int byte_width_lp   = 8;
  localparam int mask_width_lp   = data_width_lp / byte_width_lp;  // One bit per byte
  localparam int paddr_width_lp  = 22;
  localparam int ways_lp         = 8;
  localparam int sets_lp         = 64;

  localparam int byte_offset_width_lp  = $clog2(mask_width_lp);
  // A block holds one word per way
  localparam int word_offset_width_lp  = $clog2(ways_lp);
  localparam int block_offset_width_lp = word_offset_width_lp + byte_offset_width_lp;
  localparam int index_width_lp        = $clog2(sets_lp);
  localparam int tag_width_lp          = paddr_width_lp - index_width_lp
                                         - block_offset_width_lp;
  localparam int way_width_lp          = $clog2(ways_lp);
  localparam int word_addr_width_lp    = paddr_width_lp - byte_offset_width_lp;

  // Packed width of one held store, without its valid flag
  localparam int entry_width_lp = paddr_width_lp + data_width_lp + mask_width_lp
                                  + way_width_lp;

  // ============================================================
  // Occupancy encodings
  // ============================================================
  localparam logic [1:0] occ_empty_lp = 2'd0;
  localparam logic [1:0] occ_one_lp   = 2'd1;
  localparam logic [1:0] occ_two_lp   = 2'd2;

  // ============================================================
  // Physical address, cache view and word view
  // ============================================================
  typedef union packed {
    struct packed {
      logic [tag_width_lp-1:0]          tag;
      logic [index_width_lp-1:0]        index;
      logic [block_offset_width_lp-1:0] block_offset;
    } cache;  // Used by snoop
    struct packed {
      logic [word_addr_width_lp-1:0]    word_addr;
      logic [byte_offset_width_lp-1:0]  byte_offset;
    } word;   // Used by bypass
  } paddr_u;

endpackage

// File: verilog/wbuf_store_if.sv
// One store of the write buffer; v qualifies all other fields in the same cycle
`timescale 1ns/100ps

interface wbuf_store_if
  import wbuf_pkg::*;
();

  logic                     v;
  paddr_u                   addr;
  logic [data_width_lp-1:0] data;
  logic [mask_width_lp-1:0] mask;   // Byte enables
  logic [way_width_lp-1:0]  way;

  // Producer side
  modport src (
    output v,
    output addr,
    output data,
    output mask,
    output way
  );

  // Consumer side
  modport dst (
    input v,
    input addr,
    input data,
    input mask,
    input way
  );

endinterface

// File: verilog/wbuf_ctrl.sv
// Occupancy FSM for two entries; a store offered while full with yumi_i low is lost
`timescale 1ns/100ps

module wbuf_ctrl
  import wbuf_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  input  logic      yumi_i,
  wbuf_store_if.dst in_store,
  output logic      v_o,
  output logic      empty_o,
  output logic      el0_en_o,
  output logic      el1_en_o,
  output logic      mux0_sel_o,
  output logic      mux1_sel_o,
  output logic      el0_valid_o,
  output logic      el1_valid_o
);

  logic [1:0] occ_r;
  logic [1:0] occ_n;

  // ============================================================
  // Decode of occupancy
  // ============================================================
  always_comb begin
    v_o         = 1'b0;
    empty_o     = 1'b0;
    el0_en_o    = 1'b0;
    el1_en_o    = 1'b0;
    mux0_sel_o  = 1'b0;
    mux1_sel_o  = 1'b0;
    el0_valid_o = 1'b0;
    el1_valid_o = 1'b0;
    case (occ_r)
      occ_empty_lp: begin
        v_o      = in_store.v;                // Pass-through
        empty_o  = 1'b1;
        el1_en_o = in_store.v & ~yumi_i;      // Park store if not taken
      end
      occ_one_lp: begin
        v_o         = 1'b1;
        mux1_sel_o  = 1'b1;
        el1_valid_o = 1'b1;
        el0_en_o    = in_store.v & ~yumi_i;   // Newest behind el1
        el1_en_o    = in_store.v & yumi_i;    // Replace drained head
      end
      occ_two_lp: begin
        v_o         = 1'b1;
        mux0_sel_o  = 1'b1;
        mux1_sel_o  = 1'b1;
        el0_valid_o = 1'b1;
        el1_valid_o = 1'b1;
        el0_en_o    = in_store.v & yumi_i;
        el1_en_o    = yumi_i;                 // el0 shifts up
      end
      default: begin
      end
    endcase
  end

  // Plus one per arriving store, minus one per drain
  assign occ_n = occ_r + {1'b0, in_store.v} - {1'b0, v_o & yumi_i};

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      occ_r <= occ_empty_lp;
    end else begin
      occ_r <= occ_n;
    end
  end

endmodule

// File: verilog/wbuf_queue.sv
// Two-entry store storage without reset; entry contents are only meaningful when flagged valid
`timescale 1ns/100ps

module wbuf_queue
  import wbuf_pkg::*;
(
  input  logic                     clk_i,
  wbuf_store_if.dst                in_store,
  input  logic                     el0_en_i,
  input  logic                     el1_en_i,
  input  logic                     mux0_sel_i,
  input  logic                     mux1_sel_i,
  input  logic                     el0_valid_i,
  input  logic                     el1_valid_i,
  wbuf_store_if.src                el0,
  wbuf_store_if.src                el1,
  output paddr_u                   addr_o,
  output logic [data_width_lp-1:0] data_o,
  output logic [mask_width_lp-1:0] mask_o,
  output logic [way_width_lp-1:0]  way_o
);

  logic [entry_width_lp-1:0] in_word;
  logic [entry_width_lp-1:0] el0_r;   // Newer held store
  logic [entry_width_lp-1:0] el1_r;   // Oldest held store
  logic [entry_width_lp-1:0] el1_n;
  logic [entry_width_lp-1:0] out_word;

  assign in_word = {in_store.addr, in_store.data, in_store.mask, in_store.way};

  // ============================================================
  // Storage and shift path
  // ============================================================
  assign el1_n = mux0_sel_i ? el0_r : in_word;

  always_ff @(posedge clk_i) begin
    if (el0_en_i) begin
      el0_r <= in_word;
    end
    if (el1_en_i) begin
      el1_r <= el1_n;
    end
  end

  // ============================================================
  // Drain side
  // ============================================================
  // Head entry, or the arriving store when nothing is held
  assign out_word = mux1_sel_i ? el1_r : in_word;

  assign {addr_o, data_o, mask_o, way_o} = out_word;

  // Held entries for lookups
  assign el0.v = el0_valid_i;
  assign {el0.addr, el0.data, el0.mask, el0.way} = el0_r;

  assign el1.v = el1_valid_i;
  assign {el1.addr, el1.data, el1.mask, el1.way} = el1_r;

endmodule

// File: verilog/wbuf_bypass.sv
// Load bypass merge; result registers on bypass_v_i and lanes without a hit read as zero
`timescale 1ns/100ps

module wbuf_bypass
  import wbuf_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     bypass_v_i,
  input  paddr_u                   bypass_addr_i,
  wbuf_store_if.dst                in_store,
  wbuf_store_if.dst                el0,
  wbuf_store_if.dst                el1,
  output logic [data_width_lp-1:0] bypass_data_o,
  output logic [mask_width_lp-1:0] bypass_mask_o
);

  logic                     hit_in;
  logic                     hit_el0;
  logic                     hit_el1;
  logic [mask_width_lp-1:0] sel_in;
  logic [mask_width_lp-1:0] sel_el0;
  logic [mask_width_lp-1:0] sel_el1;
  logic [mask_width_lp-1:0] mask_n;
  logic [data_width_lp-1:0] data_n;

  // ============================================================
  // Word match per entry
  // ============================================================
  assign hit_in  = in_store.v
                   & (in_store.addr.word.word_addr == bypass_addr_i.word.word_addr);
  assign hit_el0 = el0.v & (el0.addr.word.word_addr == bypass_addr_i.word.word_addr);
  assign hit_el1 = el1.v & (el1.addr.word.word_addr == bypass_addr_i.word.word_addr);

  assign sel_in  = {mask_width_lp{hit_in}} & in_store.mask;
  assign sel_el0 = {mask_width_lp{hit_el0}} & el0.mask;
  assign sel_el1 = {mask_width_lp{hit_el1}} & el1.mask;

  assign mask_n = sel_in | sel_el0 | sel_el1;

  // Newest writer per byte lane
  always_comb begin
    data_n = '0;
    for (int b = 0; b < mask_width_lp; b++) begin
      if (sel_in[b]) begin
        data_n[b*byte_width_lp +: byte_width_lp] = in_store.data[b*byte_width_lp +: byte_width_lp];
      end else if (sel_el0[b]) begin
        data_n[b*byte_width_lp +: byte_width_lp] = el0.data[b*byte_width_lp +: byte_width_lp];
      end else if (sel_el1[b]) begin
        data_n[b*byte_width_lp +: byte_width_lp] = el1.data[b*byte_width_lp +: byte_width_lp];
      end
    end
  end

  // ============================================================
  // Result register
  // ============================================================
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      bypass_data_o <= '0;
      bypass_mask_o <= '0;
    end else if (bypass_v_i) begin
      bypass_data_o <= data_n;
      bypass_mask_o <= mask_n;
    end
  end

endmodule

// File: verilog/wbuf_snoop.sv
// Combinational snoop on set index and way only; the tag is not compared
`timescale 1ns/100ps

module wbuf_snoop
  import wbuf_pkg::*;
(
  input  logic [index_width_lp-1:0] snoop_index_i,
  input  logic [way_width_lp-1:0]   snoop_way_i,
  wbuf_store_if.dst                 in_store,
  wbuf_store_if.dst                 el0,
  wbuf_store_if.dst                 el1,
  output logic                      snoop_match_o
);

  logic match_in;
  logic match_el0;
  logic match_el1;

  function automatic logic entry_match(input logic                    v,
                                       input paddr_u                  addr,
                                       input logic [way_width_lp-1:0] way);
    return v & (addr.cache.index == snoop_index_i) & (way == snoop_way_i);
  endfunction

  assign match_in  = entry_match(in_store.v, in_store.addr, in_store.way);  // Arriving store
  assign match_el0 = entry_match(el0.v, el0.addr, el0.way);
  assign match_el1 = entry_match(el1.v, el1.addr, el1.way);

  assign snoop_match_o = match_in | match_el0 | match_el1;

endmodule

// File: verilog/dcache_wbuf.sv
// Data cache store write buffer; caller must not offer a store while two are held and yumi_i is low
`timescale 1ns/100ps

module dcache_wbuf
  import wbuf_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      reset_i,
  // Incoming store
  input  logic                      v_i,
  input  logic [paddr_width_lp-1:0] addr_i,
  input  logic [data_width_lp-1:0]  data_i,
  input  logic [mask_width_lp-1:0]  mask_i,
  input  logic [way_width_lp-1:0]   way_i,
  // Drain to the data array
  output logic                      v_o,
  output logic [paddr_width_lp-1:0] addr_o,
  output logic [data_width_lp-1:0]  data_o,
  output logic [mask_width_lp-1:0]  mask_o,
  output logic [way_width_lp-1:0]   way_o,
  input  logic                      yumi_i,
  output logic                      empty_o,
  // Load bypass
  input  logic                      bypass_v_i,
  input  logic [paddr_width_lp-1:0] bypass_addr_i,
  output logic [data_width_lp-1:0]  bypass_data_o,
  output logic [mask_width_lp-1:0]  bypass_mask_o,
  // Coherence snoop
  input  logic [index_width_lp-1:0] snoop_index_i,
  input  logic [way_width_lp-1:0]   snoop_way_i,
  output logic                      snoop_match_o
);

  logic el0_en;
  logic el1_en;
  logic mux0_sel;
  logic mux1_sel;
  logic el0_valid;
  logic el1_valid;

  wbuf_store_if in_store ();
  wbuf_store_if el0 ();
  wbuf_store_if el1 ();

  assign in_store.v    = v_i;
  assign in_store.addr = addr_i;
  assign in_store.data = data_i;
  assign in_store.mask = mask_i;
  assign in_store.way  = way_i;

  // ============================================================
  // Control and storage
  // ============================================================
  wbuf_ctrl ctrl (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .yumi_i      (yumi_i),
    .in_store    (in_store),
    .v_o         (v_o),
    .empty_o     (empty_o),
    .el0_en_o    (el0_en),
    .el1_en_o    (el1_en),
    .mux0_sel_o  (mux0_sel),
    .mux1_sel_o  (mux1_sel),
    .el0_valid_o (el0_valid),
    .el1_valid_o (el1_valid)
  );

  wbuf_queue queue (
    .clk_i       (clk_i),
    .in_store    (in_store),
    .el0_en_i    (el0_en),
    .el1_en_i    (el1_en),
    .mux0_sel_i  (mux0_sel),
    .mux1_sel_i  (mux1_sel),
    .el0_valid_i (el0_valid),
    .el1_valid_i (el1_valid),
    .el0         (el0),
    .el1         (el1),
    .addr_o      (addr_o),
    .data_o      (data_o),
    .mask_o      (mask_o),
    .way_o       (way_o)
  );

  // ============================================================
  // Lookups
  // ============================================================
  wbuf_bypass bypass (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .bypass_v_i    (bypass_v_i),
    .bypass_addr_i (bypass_addr_i),
    .in_store      (in_store),
    .el0           (el0),
    .el1           (el1),
    .bypass_data_o (bypass_data_o),
    .bypass_mask_o (bypass_mask_o)
  );

  wbuf_snoop snoop (
    .snoop_index_i (snoop_index_i),
    .snoop_way_i   (snoop_way_i),
    .in_store      (in_store),
    .el0           (el0),
    .el1           (el1),
    .snoop_match_o (snoop_match_o)
  );

endmodule

// File: test/wbuf_chk.sv
// Bound into wbuf_ctrl; checks hold only while the caller never offers a store to a full buffer
`timescale 1ns/100ps

module wbuf_chk
  import wbuf_pkg::*;
(
  input logic       clk_i,
  input logic       reset_i,
  input logic [1:0] occ_i,
  input logic       drain_v_i,
  input logic       empty_i,
  input logic       yumi_i
);

  // ============================================================
  // Occupancy and drain invariants
  // ============================================================
  occ_bound_a: assert property (@(posedge clk_i) disable iff (reset_i)
    occ_i <= occ_two_lp)
    else $error("occupancy above two entries");

  empty_flag_a: assert property (@(posedge clk_i) disable iff (reset_i)
    empty_i == (occ_i == occ_empty_lp))
    else $error("empty flag disagrees with occupancy");

  // Valid drain store stays up until taken
  drain_hold_a: assert property (@(posedge clk_i) disable iff (reset_i)
    drain_v_i && !yumi_i |=> drain_v_i)
    else $error("drain valid dropped without yumi");

endmodule

bind wbuf_ctrl wbuf_chk chk (
  .clk_i     (clk_i),
  .reset_i   (reset_i),
  .occ_i     (occ_r),
  .drain_v_i (v_o),
  .empty_i   (empty_o),
  .yumi_i    (yumi_i)
);

// File: test/tb_dcache_wbuf.sv
// Directed tests of the write buffer; stores are never offered while two are held and yumi is low
`timescale 1ns/100ps

module tb_dcache_wbuf
  import wbuf_pkg::*;
();

  localparam int clk_period_lp      = 10;
  localparam int reset_cycles_lp    = 4;
  localparam int num_tests_lp       = 5;
  localparam int cycles_per_test_lp = 20;
  localparam int watchdog_ns_lp     = (reset_cycles_lp + num_tests_lp * cycles_per_test_lp)
                                      * clk_period_lp;

  typedef struct packed {
    paddr_u                   addr;
    logic [data_width_lp-1:0] data;
    logic [mask_width_lp-1:0] mask;
    logic [way_width_lp-1:0]  way;
  } store_t;

  logic                      clk;
  logic                      reset;
  logic                      v;
  paddr_u                    addr;
  logic [data_width_lp-1:0]  data;
  logic [mask_width_lp-1:0]  mask;
  logic [way_width_lp-1:0]   way;
  logic                      yumi;
  logic                      drain_v;
  paddr_u                    drain_addr;
  logic [data_width_lp-1:0]  drain_data;
  logic [mask_width_lp-1:0]  drain_mask;
  logic [way_width_lp-1:0]   drain_way;
  logic                      empty;
  logic                      bypass_v;
  paddr_u                    bypass_addr;
  logic [data_width_lp-1:0]  bypass_data;
  logic [mask_width_lp-1:0]  bypass_mask;
  logic [index_width_lp-1:0] snoop_index;
  logic [way_width_lp-1:0]   snoop_way;
  logic                      snoop_match;

  // Reference model state
  store_t                   model_q[$];   // Oldest at the front
  logic [data_width_lp-1:0] exp_byp_data;
  logic [mask_width_lp-1:0] exp_byp_mask;
  logic [31:0]              lcg_state = 32'ha7a98e3a;
  store_t                   idle_s = '0;

  dcache_wbuf DUT (
    .clk_i         (clk),
    .reset_i       (reset),
    .v_i           (v),
    .addr_i        (addr),
    .data_i        (data),
    .mask_i        (mask),
    .way_i         (way),
    .v_o           (drain_v),
    .addr_o        (drain_addr),
    .data_o        (drain_data),
    .mask_o        (drain_mask),
    .way_o         (drain_way),
    .yumi_i        (yumi),
    .empty_o       (empty),
    .bypass_v_i    (bypass_v),
    .bypass_addr_i (bypass_addr),
    .bypass_data_o (bypass_data),
    .bypass_mask_o (bypass_mask),
    .snoop_index_i (snoop_index),
    .snoop_way_i   (snoop_way),
    .snoop_match_o (snoop_match)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period_lp / 2) clk = ~clk;
  end

  // ============================================================
  // Stimulus helpers and compare tasks
  // ============================================================
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic paddr_u make_addr(input logic [tag_width_lp-1:0] tag,
                                       input logic [index_width_lp-1:0] index,
                                       input logic [block_offset_width_lp-1:0] offset);
    paddr_u a;
    a.cache.tag          = tag;
    a.cache.index        = index;
    a.cache.block_offset = offset;
    return a;
  endfunction

  function automatic store_t make_store(input paddr_u a, input logic [way_width_lp-1:0] w);
    store_t      s;
    logic [31:0] r;
    r      = next_rand();
    s.addr = a;
    s.data = r;
    r      = next_rand();
    s.mask = r[31 -: mask_width_lp];   // Upper bits of the LCG
    s.way  = w;
    return s;
  endfunction

  task automatic report_mismatch(input string what);
    $display("mismatch at %0t: %s", $time, what);
    $display("Simulation failed");
    $fatal(1, "stopped at first wrong value");
  endtask

  task automatic compare_store(input paddr_u got_addr,
                               input logic [data_width_lp-1:0] got_data,
                               input logic [mask_width_lp-1:0] got_mask,
                               input logic [way_width_lp-1:0] got_way,
                               input store_t exp, input string what);
    if (got_addr !== exp.addr || got_data !== exp.data || got_mask !== exp.mask
        || got_way !== exp.way) begin
      report_mismatch($sformatf("%s got %h %h %h %h expected %h %h %h %h", what, got_addr,
                                got_data, got_mask, got_way, exp.addr, exp.data, exp.mask,
                                exp.way));
    end
  endtask

  task automatic compare_bypass(input logic [data_width_lp-1:0] got_data,
                                input logic [mask_width_lp-1:0] got_mask,
                                input logic [data_width_lp-1:0] exp_data,
                                input logic [mask_width_lp-1:0] exp_mask, input string what);
    if (got_data !== exp_data || got_mask !== exp_mask) begin
      report_mismatch($sformatf("%s got %h/%h expected %h/%h", what, got_data, got_mask,
                                exp_data, exp_mask));
    end
  endtask

  task automatic compare_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      report_mismatch($sformatf("%s got %b expected %b", what, got, exp));
    end
  endtask

  // ============================================================
  // Reference model
  // ============================================================
  function automatic logic predict_snoop(input logic nv, input store_t s,
                                         input logic [index_width_lp-1:0] si,
                                         input logic [way_width_lp-1:0] sw);
    logic hit;
    hit = nv && s.addr.cache.index == si && s.way == sw;
    foreach (model_q[i]) begin
      if (model_q[i].addr.cache.index == si && model_q[i].way == sw) hit = 1'b1;
    end
    return hit;
  endfunction

  // Lanes already taken by a newer store are skipped
  function automatic void merge_entry(input store_t e, input paddr_u la);
    if (e.addr.word.word_addr == la.word.word_addr) begin
      for (int b = 0; b < mask_width_lp; b++) begin
        if (e.mask[b] && !exp_byp_mask[b]) begin
          exp_byp_data[b*byte_width_lp +: byte_width_lp] = e.data[b*byte_width_lp +: byte_width_lp];
          exp_byp_mask[b] = 1'b1;
        end
      end
    end
  endfunction

  function automatic void predict_bypass(input logic nv, input store_t s, input paddr_u la);
    exp_byp_data = '0;
    exp_byp_mask = '0;
    if (nv) merge_entry(s, la);   // Arriving store is the newest
    for (int i = model_q.size() - 1; i >= 0; i--) begin
      merge_entry(model_q[i], la);
    end
  endfunction

  function automatic void update_model(input logic nv, input store_t s, input logic take);
    logic consumed;
    consumed = 1'b0;
    if (take) begin
      if (model_q.size() != 0) void'(model_q.pop_front());
      else consumed = 1'b1;   // Straight through
    end
    if (nv && !consumed) model_q.push_back(s);
  endfunction

  // Drive at the rising edge and check at the falling edge
  task automatic run_cycle(input logic nv, input store_t s, input logic ny, input logic nbv,
                           input paddr_u nba, input logic [index_width_lp-1:0] nsi,
                           input logic [way_width_lp-1:0] nsw);
    logic exp_v;
    @(posedge clk);
    v           <= nv;
    addr        <= s.addr;
    data        <= s.data;
    mask        <= s.mask;
    way         <= s.way;
    yumi        <= ny;
    bypass_v    <= nbv;
    bypass_addr <= nba;
    snoop_index <= nsi;
    snoop_way   <= nsw;
    @(negedge clk);
    exp_v = (model_q.size() != 0) || nv;
    compare_flag(drain_v, exp_v, "drain valid");
    compare_flag(empty, model_q.size() == 0, "empty flag");
    if (exp_v) begin
      compare_store(drain_addr, drain_data, drain_mask, drain_way,
                    (model_q.size() != 0) ? model_q[0] : s, "drain store");
    end
    compare_bypass(bypass_data, bypass_mask, exp_byp_data, exp_byp_mask, "bypass result");
    compare_flag(snoop_match, predict_snoop(nv, s, nsi, nsw), "snoop match");
    if (nbv) predict_bypass(nv, s, nba);
    update_model(nv, s, ny && exp_v);
  endtask

  task automatic idle_cycle(input logic ny);
    run_cycle(1'b0, idle_s, ny, 1'b0, '0, '0, '0);
  endtask

  // ============================================================
  // Directed tests
  // ============================================================
  task automatic after_reset();
    idle_cycle(1'b0);
    compare_flag(empty, 1'b1, "empty after reset");
    compare_flag(drain_v, 1'b0, "drain valid after reset");
    compare_bypass(bypass_data, bypass_mask, '0, '0, "bypass after reset");
  endtask

  task automatic pass_through();
    store_t s;
    s = make_store(make_addr(11'h0a1, 6'd3, 5'h08), 3'd2);
    run_cycle(1'b1, s, 1'b1, 1'b0, '0, '0, '0);
    compare_flag(drain_v, 1'b1, "pass-through valid");
    compare_store(drain_addr, drain_data, drain_mask, drain_way, s, "pass-through store");
    idle_cycle(1'b0);
    compare_flag(empty, 1'b1, "empty after pass-through");
  endtask

  task automatic order_and_backpressure();
    store_t s0;
    store_t s1;
    s0 = make_store(make_addr(11'h155, 6'd10, 5'h04), 3'd1);
    s1 = make_store(make_addr(11'h2aa, 6'd33, 5'h1c), 3'd6);
    run_cycle(1'b1, s0, 1'b0, 1'b0, '0, '0, '0);
    run_cycle(1'b1, s1, 1'b0, 1'b0, '0, '0, '0);
    run_cycle(1'b0, idle_s, 1'b0, 1'b0, '0, 6'd33, 3'd6);   // Held under back-pressure
    compare_store(drain_addr, drain_data, drain_mask, drain_way, s0, "head while stalled");
    compare_flag(snoop_match, 1'b1, "snoop on newer held store");
    idle_cycle(1'b1);
    compare_store(drain_addr, drain_data, drain_mask, drain_way, s0, "first drained");
    idle_cycle(1'b1);
    compare_store(drain_addr, drain_data, drain_mask, drain_way, s1, "second drained");
    idle_cycle(1'b0);
    compare_flag(empty, 1'b1, "empty after drain");
  endtask

  task automatic bypass_merge();
    paddr_u                   w;
    store_t                   s0;
    store_t                   s1;
    store_t                   s2;
    logic [data_width_lp-1:0] merged;
    w       = make_addr(11'h3f0, 6'd21, 5'h0c);
    s0      = make_store(w, 3'd0);
    s1      = make_store(w, 3'd5);
    s2      = make_store(w, 3'd7);
    s0.mask = 4'b0011;
    s1.mask = 4'b0110;
    s2.mask = 4'b1100;
    merged  = {s2.data[31:16], s1.data[15:8], s0.data[7:0]};
    run_cycle(1'b1, s0, 1'b0, 1'b0, '0, '0, '0);
    run_cycle(1'b1, s1, 1'b0, 1'b0, '0, '0, '0);
    w.word.byte_offset = 2'd2;   // Same word, other byte
    run_cycle(1'b1, s2, 1'b1, 1'b1, w, '0, '0);
    idle_cycle(1'b1);
    compare_bypass(bypass_data, bypass_mask, merged, 4'hf, "merged bypass");
    run_cycle(1'b0, idle_s, 1'b0, 1'b1, make_addr(11'h3f0, 6'd21, 5'h10), '0, '0);
    compare_bypass(bypass_data, bypass_mask, merged, 4'hf, "merged bypass held");
    idle_cycle(1'b1);
    compare_bypass(bypass_data, bypass_mask, '0, '0, "bypass to other word");
  endtask

  task automatic snoop_lookup();
    store_t s;
    s = make_store(make_addr(11'h07e, 6'd9, 5'h14), 3'd3);
    run_cycle(1'b1, s, 1'b0, 1'b0, '0, 6'd9, 3'd3);
    compare_flag(snoop_match, 1'b1, "snoop on arriving store");
    run_cycle(1'b0, idle_s, 1'b0, 1'b0, '0, 6'd9, 3'd3);
    compare_flag(snoop_match, 1'b1, "snoop on held store");
    run_cycle(1'b0, idle_s, 1'b0, 1'b0, '0, 6'd9, 3'd4);
    compare_flag(snoop_match, 1'b0, "snoop on other way");
    run_cycle(1'b0, idle_s, 1'b1, 1'b0, '0, 6'd9, 3'd3);
    run_cycle(1'b0, idle_s, 1'b0, 1'b0, '0, 6'd9, 3'd3);
    compare_flag(snoop_match, 1'b0, "snoop after drain");
  endtask

  // ============================================================
  // Main sequence and watchdog
  // ============================================================
  initial begin
    reset        <= 1'b1;
    v            <= 1'b0;
    addr         <= '0;
    data         <= '0;
    mask         <= '0;
    way          <= '0;
    yumi         <= 1'b0;
    bypass_v     <= 1'b0;
    bypass_addr  <= '0;
    snoop_index  <= '0;
    snoop_way    <= '0;
    exp_byp_data = '0;
    exp_byp_mask = '0;
    repeat (reset_cycles_lp) @(posedge clk);
    reset <= 1'b0;
    after_reset();
    pass_through();
    order_and_backpressure();
    bypass_merge();
    snoop_lookup();
    $display("Simulation completed successfully");
    $finish;
  end

  initial begin
    #(watchdog_ns_lp);
    $display("Watchdog expired before the tests finished");
    $display("Simulation failed");
    $fatal(1, "timeout");
  end

endmodule

// File: compile.f
verilog/wbuf_pkg.sv
verilog/wbuf_store_if.sv
verilog/wbuf_ctrl.sv
verilog/wbuf_queue.sv
verilog/wbuf_bypass.sv
verilog/wbuf_snoop.sv
verilog/dcache_wbuf.sv
test/wbuf_chk.sv
test/tb_dcache_wbuf.sv

// File: Makefile
# Verilator build and run of the write buffer testbench

VERILATOR ?= verilator
TOP       ?= tb_dcache_wbuf
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(wildcard verilog/*.sv) $(wildcard test/*.sv)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Exit status of the simulator is the test result
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(BUILD_DIR)
